// ==== hw/addmul_pkg.sv ====
package addmul_pkg;

  // --------------------------------------------------------------------------
  // AXI4-Lite control port
  // --------------------------------------------------------------------------

  localparam int AXIL_ADDR_BITS = 4;
  localparam int AXIL_DATA_BITS = 32;
  localparam int AXIL_STRB_BITS = AXIL_DATA_BITS / 8;

  // Response code, only OKAY is ever returned
  localparam logic [1:0] RESP_OKAY = 2'b00;

  // Register map, index taken from address bits [3:2]
  localparam int REG_IDX_LSB  = 2;
  localparam int REG_IDX_BITS = 2;
  localparam int N_REGS       = 2;
  localparam int MUL_FACT_REG = 0;
  localparam int ADD_FACT_REG = 1;

  // --------------------------------------------------------------------------
  // Data stream
  // --------------------------------------------------------------------------

  localparam int N_LANES     = 4;
  localparam int LANE_BITS   = 32;
  localparam int FACTOR_BITS = 16;

  typedef logic [N_LANES-1:0][LANE_BITS-1:0] lane_vec_t;

  typedef struct packed {
    lane_vec_t data;
    logic      last;
  } beat_t;

  // Master to slave
  typedef struct packed {
    logic [AXIL_ADDR_BITS-1:0] awaddr;
    logic                      awvalid;
    logic [AXIL_DATA_BITS-1:0] wdata;
    logic [AXIL_STRB_BITS-1:0] wstrb;
    logic                      wvalid;
    logic                      bready;
    logic [AXIL_ADDR_BITS-1:0] araddr;
    logic                      arvalid;
    logic                      rready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      arready;
    logic [AXIL_DATA_BITS-1:0] rdata;
    logic [1:0]                rresp;
    logic                      rvalid;
  } axil_rsp_t;

endpackage

// ==== hw/stream_slice.sv ====
module stream_slice #(
  parameter type data_t = logic
) (
  input  logic  aclk,
  input  logic  aresetn,
  input  data_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output data_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  data_t main_q;
  data_t skid_q;
  logic  main_valid_q;
  logic  skid_valid_q;
  logic  in_ready_q;

  logic  in_fire;
  logic  main_load;
  logic  skid_load;

  assign in_fire = in_valid && in_ready_q;

  // Output register can take a new beat when empty or draining
  assign main_load = !main_valid_q || out_ready;

  // Stalled output, incoming beat parks in the skid entry
  assign skid_load = !main_load && in_fire;

  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      main_valid_q <= 1'b0;
      skid_valid_q <= 1'b0;
      in_ready_q   <= 1'b0;
    end
    else
    begin
      if (main_load)
      begin
        main_valid_q <= skid_valid_q || in_fire;
        skid_valid_q <= 1'b0;
        in_ready_q   <= 1'b1;
      end
      else if (skid_load)
      begin
        skid_valid_q <= 1'b1;
        in_ready_q   <= 1'b0;
      end
      else
      begin
        in_ready_q <= !skid_valid_q;
      end
    end
  end

  // Payload, skid entry takes priority over the input
  always_ff @(posedge aclk)
  begin
    if (main_load)
    begin
      main_q <= skid_valid_q ? skid_q : in_data;
    end
    if (skid_load)
    begin
      skid_q <= in_data;
    end
  end

  assign in_ready  = in_ready_q;
  assign out_data  = main_q;
  assign out_valid = main_valid_q;

endmodule

// ==== hw/addmul_cnfg_slave.sv ====
module addmul_cnfg_slave (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  addmul_pkg::axil_req_t               axil_req,
  output addmul_pkg::axil_rsp_t               axil_rsp,
  output logic [addmul_pkg::FACTOR_BITS-1:0]  mul_factor,
  output logic [addmul_pkg::FACTOR_BITS-1:0]  add_factor
);

  // --------------------------------------------------------------------------
  // Declarations
  // --------------------------------------------------------------------------

  // Write channel state
  logic [addmul_pkg::AXIL_ADDR_BITS-1:0] awaddr_q;
  logic                                  awready_q;
  logic                                  wready_q;
  logic                                  bvalid_q;
  logic                                  aw_en_q;

  // Read channel state
  logic [addmul_pkg::AXIL_ADDR_BITS-1:0] araddr_q;
  logic                                  arready_q;
  logic                                  rvalid_q;
  logic [addmul_pkg::AXIL_DATA_BITS-1:0] rdata_q;

  // Factor registers
  logic [addmul_pkg::N_REGS-1:0][addmul_pkg::AXIL_DATA_BITS-1:0] slv_reg;

  logic [addmul_pkg::REG_IDX_BITS-1:0] wr_idx;
  logic [addmul_pkg::REG_IDX_BITS-1:0] rd_idx;
  logic                                slv_reg_wren;
  logic                                slv_reg_rden;

  assign wr_idx = awaddr_q[addmul_pkg::REG_IDX_LSB +: addmul_pkg::REG_IDX_BITS];
  assign rd_idx = araddr_q[addmul_pkg::REG_IDX_LSB +: addmul_pkg::REG_IDX_BITS];

  // --------------------------------------------------------------------------
  // Write path
  // --------------------------------------------------------------------------

  // Address and data are taken together; aw_en holds off the next write
  // until the B response has been consumed
  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      awready_q <= 1'b0;
      wready_q  <= 1'b0;
      awaddr_q  <= '0;
      aw_en_q   <= 1'b1;
    end
    else
    begin
      if (!awready_q && axil_req.awvalid && axil_req.wvalid && aw_en_q)
      begin
        awready_q <= 1'b1;
        wready_q  <= 1'b1;
        awaddr_q  <= axil_req.awaddr;
        aw_en_q   <= 1'b0;
      end
      else
      begin
        awready_q <= 1'b0;
        wready_q  <= 1'b0;
        if (axil_req.bready && bvalid_q)
        begin
          aw_en_q <= 1'b1;
        end
      end
    end
  end

  assign slv_reg_wren = awready_q && axil_req.awvalid && wready_q && axil_req.wvalid;

  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      bvalid_q <= 1'b0;
    end
    else if (slv_reg_wren && !bvalid_q)
    begin
      bvalid_q <= 1'b1;
    end
    else if (axil_req.bready && bvalid_q)
    begin
      bvalid_q <= 1'b0;
    end
  end

  // Byte strobed update, unmapped indices fall through untouched
  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      slv_reg <= '0;
    end
    else if (slv_reg_wren)
    begin
      for (int r = 0; r < addmul_pkg::N_REGS; r++)
      begin
        if (wr_idx == r)
        begin
          for (int i = 0; i < addmul_pkg::AXIL_STRB_BITS; i++)
          begin
            if (axil_req.wstrb[i])
            begin
              slv_reg[r][i*8 +: 8] <= axil_req.wdata[i*8 +: 8];
            end
          end
        end
      end
    end
  end

  assign mul_factor = slv_reg[addmul_pkg::MUL_FACT_REG][addmul_pkg::FACTOR_BITS-1:0];
  assign add_factor = slv_reg[addmul_pkg::ADD_FACT_REG][addmul_pkg::FACTOR_BITS-1:0];

  // --------------------------------------------------------------------------
  // Read path
  // --------------------------------------------------------------------------

  // No new address while a read response is still pending
  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      arready_q <= 1'b0;
      araddr_q  <= '0;
    end
    else if (!arready_q && axil_req.arvalid && !rvalid_q)
    begin
      arready_q <= 1'b1;
      araddr_q  <= axil_req.araddr;
    end
    else
    begin
      arready_q <= 1'b0;
    end
  end

  assign slv_reg_rden = arready_q && axil_req.arvalid && !rvalid_q;

  always_ff @(posedge aclk or negedge aresetn)
  begin
    if (!aresetn)
    begin
      rvalid_q <= 1'b0;
    end
    else if (slv_reg_rden)
    begin
      rvalid_q <= 1'b1;
    end
    else if (rvalid_q && axil_req.rready)
    begin
      rvalid_q <= 1'b0;
    end
  end

  // Read data held until rready
  always_ff @(posedge aclk)
  begin
    if (slv_reg_rden)
    begin
      case (rd_idx)
        addmul_pkg::MUL_FACT_REG: rdata_q <= slv_reg[addmul_pkg::MUL_FACT_REG];
        addmul_pkg::ADD_FACT_REG: rdata_q <= slv_reg[addmul_pkg::ADD_FACT_REG];
        default:                  rdata_q <= '0;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Response bundle
  // --------------------------------------------------------------------------

  always_comb
  begin
    axil_rsp.awready = awready_q;
    axil_rsp.wready  = wready_q;
    axil_rsp.bresp   = addmul_pkg::RESP_OKAY;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.arready = arready_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = addmul_pkg::RESP_OKAY;
    axil_rsp.rvalid  = rvalid_q;
  end

endmodule

// ==== hw/addmul_mul_stage.sv ====
module addmul_mul_stage (
  input  logic                               aclk,
  input  logic                               aresetn,
  input  logic [addmul_pkg::FACTOR_BITS-1:0] mul_factor,
  input  addmul_pkg::beat_t                  s_beat,
  input  logic                               s_valid,
  output logic                               s_ready,
  output addmul_pkg::beat_t                  m_beat,
  output logic                               m_valid,
  input  logic                               m_ready
);

  logic [addmul_pkg::LANE_BITS-1:0] factor_ext;
  addmul_pkg::beat_t                prod_beat;

  assign factor_ext = {{(addmul_pkg::LANE_BITS - addmul_pkg::FACTOR_BITS){1'b0}}, mul_factor};

  // Product per lane, low 32 bits kept
  always_comb
  begin
    prod_beat.last = s_beat.last;
    for (int i = 0; i < addmul_pkg::N_LANES; i++)
    begin
      prod_beat.data[i] = s_beat.data[i] * factor_ext;
    end
  end

  // Factor is captured with the beat on acceptance
  stream_slice #(
    .data_t (addmul_pkg::beat_t)
  ) u_slice (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_data   (prod_beat),
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .out_data  (m_beat),
    .out_valid (m_valid),
    .out_ready (m_ready)
  );

endmodule

// ==== hw/addmul_add_stage.sv ====
module addmul_add_stage (
  input  logic                               aclk,
  input  logic                               aresetn,
  input  logic [addmul_pkg::FACTOR_BITS-1:0] add_factor,
  input  addmul_pkg::beat_t                  s_beat,
  input  logic                               s_valid,
  output logic                               s_ready,
  output addmul_pkg::beat_t                  m_beat,
  output logic                               m_valid,
  input  logic                               m_ready
);

  logic [addmul_pkg::LANE_BITS-1:0] factor_ext;
  addmul_pkg::beat_t                sum_beat;

  assign factor_ext = {{(addmul_pkg::LANE_BITS - addmul_pkg::FACTOR_BITS){1'b0}}, add_factor};

  // Sum per lane, carry out of bit 31 dropped
  always_comb
  begin
    sum_beat.last = s_beat.last;
    for (int i = 0; i < addmul_pkg::N_LANES; i++)
    begin
      sum_beat.data[i] = s_beat.data[i] + factor_ext;
    end
  end

  // Output register of the pipeline
  stream_slice #(
    .data_t (addmul_pkg::beat_t)
  ) u_slice (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_data   (sum_beat),
    .in_valid  (s_valid),
    .in_ready  (s_ready),
    .out_data  (m_beat),
    .out_valid (m_valid),
    .out_ready (m_ready)
  );

endmodule

// ==== hw/addmul_top.sv ====
module addmul_top (
  input  logic                  aclk,
  input  logic                  aresetn,
  input  addmul_pkg::axil_req_t axil_req,
  output addmul_pkg::axil_rsp_t axil_rsp,
  input  addmul_pkg::beat_t     s_beat,
  input  logic                  s_valid,
  output logic                  s_ready,
  output addmul_pkg::beat_t     m_beat,
  output logic                  m_valid,
  input  logic                  m_ready
);

  logic [addmul_pkg::FACTOR_BITS-1:0] mul_factor;
  logic [addmul_pkg::FACTOR_BITS-1:0] add_factor;

  // Between multiply and add
  addmul_pkg::beat_t mid_beat;
  logic              mid_valid;
  logic              mid_ready;

  addmul_cnfg_slave u_cnfg (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .axil_req   (axil_req),
    .axil_rsp   (axil_rsp),
    .mul_factor (mul_factor),
    .add_factor (add_factor)
  );

  addmul_mul_stage u_mul (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .mul_factor (mul_factor),
    .s_beat     (s_beat),
    .s_valid    (s_valid),
    .s_ready    (s_ready),
    .m_beat     (mid_beat),
    .m_valid    (mid_valid),
    .m_ready    (mid_ready)
  );

  addmul_add_stage u_add (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .add_factor (add_factor),
    .s_beat     (mid_beat),
    .s_valid    (mid_valid),
    .s_ready    (mid_ready),
    .m_beat     (m_beat),
    .m_valid    (m_valid),
    .m_ready    (m_ready)
  );

endmodule

// ==== include/addmul_tb_tasks.svh ====
`ifndef ADDMUL_TB_TASKS_SVH
`define ADDMUL_TB_TASKS_SVH

// Included inside the testbench module and works on aclk, axil_req, axil_rsp,
// s_beat, s_valid, s_ready and reg_errors of that scope
// All tasks start at a falling edge

// ----------------------------------------------------------------------------
// AXI4-Lite master
// ----------------------------------------------------------------------------

task automatic axil_write(
  input logic [addmul_pkg::AXIL_ADDR_BITS-1:0] addr,
  input logic [addmul_pkg::AXIL_DATA_BITS-1:0] data,
  input logic [addmul_pkg::AXIL_STRB_BITS-1:0] strb
);
  axil_req.awaddr  = addr;
  axil_req.awvalid = 1'b1;
  axil_req.wdata   = data;
  axil_req.wstrb   = strb;
  axil_req.wvalid  = 1'b1;
  axil_req.bready  = 1'b1;
  // Hold until awready as the handshake lands on the next rising edge
  do
    @(negedge aclk);
  while (!axil_rsp.awready);
  assert (axil_rsp.wready === 1'b1)
  else
  begin
    reg_errors++;
    $display("** Error at %0t: wready expected 1, got %b", $time, axil_rsp.wready);
  end
  @(negedge aclk);
  axil_req.awvalid = 1'b0;
  axil_req.wvalid  = 1'b0;
  while (!axil_rsp.bvalid)
    @(negedge aclk);
  assert (axil_rsp.bresp === 2'b00)
  else
  begin
    reg_errors++;
    $display("** Error at %0t: bresp expected 00, got %b", $time, axil_rsp.bresp);
  end
  @(negedge aclk);
  axil_req.bready = 1'b0;
endtask

task automatic axil_read(
  input  logic [addmul_pkg::AXIL_ADDR_BITS-1:0] addr,
  output logic [addmul_pkg::AXIL_DATA_BITS-1:0] data
);
  axil_req.araddr  = addr;
  axil_req.arvalid = 1'b1;
  axil_req.rready  = 1'b1;
  do
    @(negedge aclk);
  while (!axil_rsp.arready);
  @(negedge aclk);
  axil_req.arvalid = 1'b0;
  while (!axil_rsp.rvalid)
    @(negedge aclk);
  data = axil_rsp.rdata;
  assert (axil_rsp.rresp === 2'b00)
  else
  begin
    reg_errors++;
    $display("** Error at %0t: rresp expected 00, got %b", $time, axil_rsp.rresp);
  end
  @(negedge aclk);
  axil_req.rready = 1'b0;
endtask

// ----------------------------------------------------------------------------
// Stream source
// ----------------------------------------------------------------------------

// Leaves s_valid high on return so back to back calls give a gapless burst
task automatic send_beat(input addmul_pkg::beat_t beat);
  s_beat  = beat;
  s_valid = 1'b1;
  while (!s_ready)
    @(negedge aclk);
  @(negedge aclk);
endtask

// Expected output from the raw 32-bit register contents
function automatic addmul_pkg::beat_t ref_beat(
  input addmul_pkg::beat_t                  beat,
  input logic [addmul_pkg::AXIL_DATA_BITS-1:0] mul_reg,
  input logic [addmul_pkg::AXIL_DATA_BITS-1:0] add_reg
);
  addmul_pkg::beat_t                res;
  logic [addmul_pkg::LANE_BITS-1:0] mul_ext;
  logic [addmul_pkg::LANE_BITS-1:0] add_ext;
  mul_ext = {{(addmul_pkg::LANE_BITS - addmul_pkg::FACTOR_BITS){1'b0}},
             mul_reg[addmul_pkg::FACTOR_BITS-1:0]};
  add_ext = {{(addmul_pkg::LANE_BITS - addmul_pkg::FACTOR_BITS){1'b0}},
             add_reg[addmul_pkg::FACTOR_BITS-1:0]};
  res.last = beat.last;
  for (int i = 0; i < addmul_pkg::N_LANES; i++)
    res.data[i] = beat.data[i] * mul_ext + add_ext;
  return res;
endfunction

`endif

// ==== verif/addmul_tb.sv ====
module addmul_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 40;

  // Beat counts per phase size the watchdog as well
  localparam int N_ZERO  = 8;
  localparam int N_FULL  = 32;
  localparam int N_RAND  = 200;
  localparam int N_WRAP  = 32;
  localparam int TOTAL_BEATS = N_ZERO + N_FULL + N_RAND + 2 * N_WRAP;
  localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 500;

  logic                  aclk = 1'b0;
  logic                  aresetn;
  addmul_pkg::axil_req_t axil_req;
  addmul_pkg::axil_rsp_t axil_rsp;
  addmul_pkg::beat_t     s_beat;
  logic                  s_valid;
  logic                  s_ready;
  addmul_pkg::beat_t     m_beat;
  logic                  m_valid;
  logic                  m_ready;

  integer seed = 32'h6179;

  // Register contents as last written by the testbench
  logic [addmul_pkg::AXIL_DATA_BITS-1:0] shadow_reg [addmul_pkg::N_REGS];

  addmul_pkg::beat_t exp_q[$];
  int unsigned       acc_q[$];
  int unsigned       cycle = 0;
  int                sent_count = 0;
  int                recv_count = 0;
  int                reg_errors = 0;
  int                data_errors = 0;
  int                stream_errors = 0;
  bit                latency_mode = 1'b0;
  bit                stall_mode = 1'b0;

  addmul_top DUT (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .s_beat   (s_beat),
    .s_valid  (s_valid),
    .s_ready  (s_ready),
    .m_beat   (m_beat),
    .m_valid  (m_valid),
    .m_ready  (m_ready)
  );

  `include "addmul_tb_tasks.svh"

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  // Sink back-pressure
  always @(negedge aclk)
  begin
    m_ready = stall_mode ? ({$random(seed)} % 4 != 0) : 1'b1;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic write_reg(
    input logic [addmul_pkg::AXIL_ADDR_BITS-1:0] addr,
    input logic [addmul_pkg::AXIL_DATA_BITS-1:0] data,
    input logic [addmul_pkg::AXIL_STRB_BITS-1:0] strb
  );
    int idx;
    idx = addr[addmul_pkg::REG_IDX_LSB +: addmul_pkg::REG_IDX_BITS];
    axil_write(addr, data, strb);
    if (idx < addmul_pkg::N_REGS)
    begin
      for (int i = 0; i < addmul_pkg::AXIL_STRB_BITS; i++)
      begin
        if (strb[i])
          shadow_reg[idx][i*8 +: 8] = data[i*8 +: 8];
      end
    end
  endtask

  task automatic check_reg(input logic [addmul_pkg::AXIL_ADDR_BITS-1:0] addr);
    logic [addmul_pkg::AXIL_DATA_BITS-1:0] got;
    logic [addmul_pkg::AXIL_DATA_BITS-1:0] exp;
    int idx;
    idx = addr[addmul_pkg::REG_IDX_LSB +: addmul_pkg::REG_IDX_BITS];
    // Unmapped reads give 0
    exp = (idx < addmul_pkg::N_REGS) ? shadow_reg[idx] : '0;
    axil_read(addr, got);
    assert (got === exp)
    else
    begin
      reg_errors++;
      $display("** Error at %0t: rdata @0x%h expected %h, got %h", $time, addr, exp, got);
    end
  endtask

  // Random lanes or corner values in the first beat of a burst
  task automatic make_beat(input bit corner, input logic last, output addmul_pkg::beat_t beat);
    for (int i = 0; i < addmul_pkg::N_LANES; i++)
      beat.data[i] = $random(seed);
    if (corner)
    begin
      beat.data[0] = 32'hffff_ffff;
      beat.data[1] = 32'h8000_0000;
      beat.data[2] = 32'h0000_ffff;
      beat.data[3] = 32'h0000_0001;
    end
    beat.last = last;
  endtask

  task automatic send_burst(input int n_beats, input bit with_gaps);
    addmul_pkg::beat_t beat;
    logic              last;
    int                gap;
    for (int b = 0; b < n_beats; b++)
    begin
      if (with_gaps)
        last = ({$random(seed)} % 6 == 0);
      else
        last = (b % 8 == 7) || (b == n_beats - 1);
      make_beat(b == 0, last, beat);
      if (with_gaps && ({$random(seed)} % 3 == 0))
      begin
        gap = 1 + {$random(seed)} % 4;
        s_valid = 1'b0;
        repeat (gap) @(negedge aclk);
      end
      send_beat(beat);
      sent_count++;
    end
    s_valid = 1'b0;
  endtask

  task automatic wait_drain;
    while (exp_q.size() != 0)
      @(negedge aclk);
    repeat (4) @(negedge aclk);
  endtask

  // --------------------------------------------------------------------------
  // Comparison
  // --------------------------------------------------------------------------

  always @(posedge aclk)
  begin : compare
    addmul_pkg::beat_t exp_beat;
    int unsigned       acc_cycle;
    if (aresetn)
    begin
      if (m_valid && m_ready)
      begin
        assert (exp_q.size() != 0)
        else
        begin
          stream_errors++;
          $display("Output beat at %0t arrived with no beat outstanding", $time);
        end
        if (exp_q.size() != 0)
        begin
          exp_beat  = exp_q.pop_front();
          acc_cycle = acc_q.pop_front();
          recv_count++;
          for (int i = 0; i < addmul_pkg::N_LANES; i++)
          begin
            assert (m_beat.data[i] === exp_beat.data[i])
            else
            begin
              data_errors++;
              $display("** Error at %0t: m_beat.data[%0d] expected %h, got %h",
                       $time, i, exp_beat.data[i], m_beat.data[i]);
            end
          end
          assert (m_beat.last === exp_beat.last)
          else
          begin
            data_errors++;
            $display("** Error at %0t: m_beat.last expected %b, got %b",
                     $time, exp_beat.last, m_beat.last);
          end
          if (latency_mode)
          begin
            assert (cycle - acc_cycle == 2)
            else
            begin
              stream_errors++;
              $display("** Error at %0t: latency expected 2, got %0d",
                       $time, cycle - acc_cycle);
            end
          end
        end
      end
      // Full rate means the source is never held off
      if (latency_mode && s_valid)
      begin
        assert (s_ready === 1'b1)
        else
        begin
          stream_errors++;
          $display("** Error at %0t: s_ready expected 1, got %b", $time, s_ready);
        end
      end
      if (s_valid && s_ready)
      begin
        exp_q.push_back(ref_beat(s_beat, shadow_reg[0], shadow_reg[1]));
        acc_q.push_back(cycle);
      end
      cycle++;
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  initial
  begin
    aresetn  = 1'b0;
    axil_req = '0;
    s_beat   = '0;
    s_valid  = 1'b0;
    m_ready  = 1'b0;
    for (int r = 0; r < addmul_pkg::N_REGS; r++)
      shadow_reg[r] = '0;
    repeat (2) @(negedge aclk);
    aresetn = 1'b1;

    assert (!m_valid && !s_ready && !axil_rsp.awready && !axil_rsp.wready &&
            !axil_rsp.bvalid && !axil_rsp.arready && !axil_rsp.rvalid)
    else
    begin
      stream_errors++;
      $display("Outputs not idle right after reset at %0t", $time);
    end

    // Zero factors after reset give zero lanes
    check_reg(4'h0);
    check_reg(4'h4);
    send_burst(N_ZERO, 1'b0);
    wait_drain();

    // Register map
    write_reg(4'h0, 32'hdead_beef, 4'hf);
    write_reg(4'h4, 32'h1234_5678, 4'hf);
    check_reg(4'h0);
    check_reg(4'h4);
    write_reg(4'h0, 32'haabb_ccdd, 4'b0101);
    write_reg(4'h4, 32'h99ee_0011, 4'b1010);
    check_reg(4'h0);
    check_reg(4'h4);
    write_reg(4'h8, 32'hffff_ffff, 4'hf);
    write_reg(4'hc, 32'h5555_aaaa, 4'hf);
    check_reg(4'h8);
    check_reg(4'hc);
    check_reg(4'h0);
    check_reg(4'h4);

    // Full rate with fixed latency
    write_reg(4'h0, 32'h5a5a_0007, 4'hf);
    write_reg(4'h4, 32'hffff_0101, 4'hf);
    latency_mode = 1'b1;
    send_burst(N_FULL, 1'b0);
    wait_drain();
    latency_mode = 1'b0;

    // Back-pressure and input gaps
    stall_mode = 1'b1;
    send_burst(N_RAND, 1'b1);
    wait_drain();
    stall_mode = 1'b0;

    // Bit 15 set in both factors so lanes wrap
    write_reg(4'h0, 32'h0000_ffff, 4'hf);
    write_reg(4'h4, 32'h0000_8001, 4'hf);
    send_burst(N_WRAP, 1'b0);
    wait_drain();
    write_reg(4'h0, 32'hffff_8000, 4'hf);
    write_reg(4'h4, 32'h0001_ffff, 4'hf);
    stall_mode = 1'b1;
    send_burst(N_WRAP, 1'b1);
    wait_drain();
    stall_mode = 1'b0;

    assert (recv_count == sent_count)
    else
    begin
      stream_errors++;
      $display("Sent %0d beats but received %0d", sent_count, recv_count);
    end

    $display("Errors: register %0d, data %0d, stream %0d",
             reg_errors, data_errors, stream_errors);
    if (reg_errors + data_errors + stream_errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, the stream or the register port stopped responding",
             WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+include
hw/addmul_pkg.sv
hw/stream_slice.sv
hw/addmul_cnfg_slave.sv
hw/addmul_mul_stage.sv
hw/addmul_add_stage.sv
hw/addmul_top.sv
verif/addmul_tb.sv

// ==== Bender.yml ====
package:
  name: addmul

sources:
  - hw/addmul_pkg.sv
  - hw/stream_slice.sv
  - hw/addmul_cnfg_slave.sv
  - hw/addmul_mul_stage.sv
  - hw/addmul_add_stage.sv
  - hw/addmul_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/addmul_tb.sv
